// ==== project.f ====
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/program_counter.sv
hw/datapath.sv
hw/controller.sv
hw/cpu_top.sv
verif/tb_cpu_top.sv

// ==== Makefile ====
# Verilator build and run for the multicycle core

VERILATOR  ?= verilator
TOP        ?= tb_cpu_top
RTL_TOP    ?= cpu_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard hw/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q -F '** PASS **' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_cpu_top.sv ====
module tb_cpu_top;

	localparam logic [31:0] reset_pc = 32'h0000_0200;
	localparam int clock_period = 8;
	// words over all five programs
	localparam int program_words = 57;
	localparam int watchdog_cycles = program_words * 6 + 5 * 10 + 100;

	logic        clock;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;
	logic        dmem_read;
	logic        dmem_write;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] prog [$];
	logic [31:0] store_addr [$];
	logic [31:0] store_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	integer      seed;
	int          errors;
	int          checks;
	int          load_count;

	cpu_top #(
		.reset_pc (reset_pc)
	) uut (
		.clock      (clock),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write)
	);

	// both memories answer in the same cycle
	assign imem_data = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// store log and load count, memory updated on the same edge
	always @(negedge clock) begin
		if (dmem_write === 1'b1) begin
			store_addr.push_back(dmem_addr);
			store_data.push_back(dmem_wdata);
			dmem[dmem_addr[9:2]] = dmem_wdata;
		end
		if (dmem_read === 1'b1) begin
			load_count++;
		end
	end

	function automatic logic [31:0] sign20(logic [19:0] v);
		return {{12{v[19]}}, v};
	endfunction

	function automatic logic [31:0] sign15(logic [14:0] v);
		return {{17{v[14]}}, v};
	endfunction

	function automatic logic [31:0] mem_fill(logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
	endfunction

	function automatic logic [31:0] rotate_right(logic [31:0] v, logic [4:0] n);
		logic [31:0] r;
		r = v;
		repeat (n) r = {r[0], r[31:1]};
		return r;
	endfunction

	function automatic logic [31:0] reg_form(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
		logic [4:0] rb, logic [1:0] sv, logic [7:0] sub);
		cpu_isa_pkg::isa_instr_u w;
		w = '0;
		w.r.opcode = op;
		w.r.rt = rt;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.sv = sv;
		w.r.sub = sub;
		return w;
	endfunction

	// rb carries the shift amount for the immediate shifts
	function automatic logic [31:0] base_form(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
		logic [4:0] sub);
		return reg_form(cpu_isa_pkg::op_base, rt, ra, rb, 2'd0, {3'b000, sub});
	endfunction

	function automatic logic [31:0] imm_form(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
		logic [14:0] imm15);
		cpu_isa_pkg::isa_instr_u w;
		w = '0;
		w.i.opcode = op;
		w.i.rt = rt;
		w.i.imm = {5'd0, imm15};
		w.r.ra = ra;
		return w;
	endfunction

	function automatic logic [31:0] movi_word(logic [4:0] rt, logic [19:0] imm20);
		cpu_isa_pkg::isa_instr_u w;
		w = '0;
		w.i.opcode = cpu_isa_pkg::op_movi;
		w.i.rt = rt;
		w.i.imm = imm20;
		return w;
	endfunction

	// compares ra with rt, offset in halfwords
	function automatic logic [31:0] branch_word(logic sub, logic [4:0] ra, logic [4:0] rt,
		logic [13:0] off);
		cpu_isa_pkg::isa_instr_u w;
		w = '0;
		w.i.opcode = cpu_isa_pkg::op_branch;
		w.i.rt = rt;
		w.i.imm[14] = sub;
		w.i.imm[13:0] = off;
		w.r.ra = ra;
		return w;
	endfunction

	function automatic logic [31:0] jump_word(logic [23:0] off);
		cpu_isa_pkg::isa_instr_u w;
		w = '0;
		w.i.opcode = cpu_isa_pkg::op_jump;
		w.i.rt = {1'b0, off[23:20]};
		w.i.imm = off[19:0];
		return w;
	endfunction

	task automatic clear_program();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic expect_store(logic [31:0] addr, logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// unused words park the core on a jump to itself
	task automatic load_memories();
		int base;
		base = int'(reset_pc[9:2]);
		for (int i = 0; i < 256; i++) begin
			imem[i] = jump_word(24'd0);
			dmem[i] = mem_fill(32'(i) << 2);
		end
		foreach (prog[k]) begin
			imem[base + k] = prog[k];
		end
	endtask

	task automatic check_idle(string name, string phase);
		checks++;
		if (imem_addr !== reset_pc) begin
			errors++;
			$display("error %s: imem_addr %s expected %h actual %h", name, phase, reset_pc,
				imem_addr);
		end
		checks++;
		if (dmem_read !== 1'b0 || dmem_write !== 1'b0) begin
			errors++;
			$display("error %s: dmem strobes %s expected 00 actual %b%b", name, phase,
				dmem_read, dmem_write);
		end
	endtask

	task automatic start_program(string name);
		@(negedge clock);
		reset = 1'b1;
		load_memories();
		store_addr.delete();
		store_data.delete();
		load_count = 0;
		repeat (8) @(negedge clock);
		check_idle(name, "in reset");
		reset = 1'b0;
		@(negedge clock);
		check_idle(name, "after reset");
	endtask

	// six cycles per instruction, one already spent after reset
	task automatic run_program();
		repeat (prog.size() * 6 - 1) @(negedge clock);
	endtask

	task automatic compare_stores(string name);
		int n;
		checks++;
		if (store_addr.size() != exp_addr.size()) begin
			errors++;
			$display("error %s: store count expected %0d actual %0d", name, exp_addr.size(),
				store_addr.size());
		end
		n = (store_addr.size() < exp_addr.size()) ? store_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			checks += 2;
			if (store_addr[i] !== exp_addr[i]) begin
				errors++;
				$display("error %s: store %0d address expected %h actual %h", name, i,
					exp_addr[i], store_addr[i]);
			end
			if (store_data[i] !== exp_data[i]) begin
				errors++;
				$display("error %s: store %0d data expected %h actual %h", name, i,
					exp_data[i], store_data[i]);
			end
		end
	endtask

	task automatic check_skipped(string name, logic [31:0] addr);
		checks++;
		foreach (store_addr[i]) begin
			if (store_addr[i] === addr) begin
				errors++;
				$display("%s: a store reached %h on a path that should have been skipped",
					name, addr);
			end
		end
	endtask

	task automatic alu_register_ops();
		logic [19:0] a20;
		logic [19:0] b20;
		logic [14:0] c15;
		logic [31:0] va;
		logic [31:0] vb;
		a20 = 20'($random(seed));
		b20 = 20'($random(seed));
		c15 = 15'($random(seed));
		va = sign20(a20);
		vb = sign20(b20) + sign15(c15);
		clear_program();
		prog.push_back(movi_word(5'd1, a20));
		prog.push_back(movi_word(5'd2, b20));
		prog.push_back(imm_form(cpu_isa_pkg::op_addi, 5'd2, 5'd2, c15));
		prog.push_back(base_form(5'd3, 5'd1, 5'd2, cpu_isa_pkg::sub_add));
		prog.push_back(base_form(5'd4, 5'd1, 5'd2, cpu_isa_pkg::sub_sub));
		prog.push_back(base_form(5'd5, 5'd1, 5'd2, cpu_isa_pkg::sub_and));
		prog.push_back(base_form(5'd6, 5'd1, 5'd2, cpu_isa_pkg::sub_or));
		prog.push_back(base_form(5'd7, 5'd1, 5'd2, cpu_isa_pkg::sub_xor));
		for (int r = 3; r <= 7; r++) begin
			prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'(r), 5'd0, 15'(13 + r)));
		end
		prog.push_back(jump_word(24'd0));
		expect_store(32'h40, va + vb);
		expect_store(32'h44, va - vb);
		expect_store(32'h48, va & vb);
		expect_store(32'h4c, va | vb);
		expect_store(32'h50, va ^ vb);
		start_program("alu_register_ops");
		run_program();
		compare_stores("alu_register_ops");
	endtask

	task automatic shift_and_extend();
		logic [19:0] m20;
		logic [4:0]  s1;
		logic [4:0]  s2;
		logic [4:0]  s3;
		logic [14:0] n15;
		logic [14:0] za;
		logic [14:0] zb;
		logic [31:0] vm;
		// top bits forced so every extension is visible
		m20 = 20'($random(seed)) | 20'h80000;
		n15 = 15'($random(seed)) | 15'h4000;
		za = 15'($random(seed)) | 15'h4000;
		zb = 15'($random(seed)) | 15'h4000;
		s1 = 5'($random(seed));
		s2 = 5'($random(seed));
		s3 = 5'($random(seed));
		vm = sign20(m20);
		clear_program();
		prog.push_back(movi_word(5'd1, m20));
		prog.push_back(base_form(5'd2, 5'd1, s1, cpu_isa_pkg::sub_srli));
		prog.push_back(base_form(5'd3, 5'd1, s2, cpu_isa_pkg::sub_slli));
		prog.push_back(base_form(5'd4, 5'd1, s3, cpu_isa_pkg::sub_rotri));
		prog.push_back(imm_form(cpu_isa_pkg::op_addi, 5'd5, 5'd1, n15));
		prog.push_back(imm_form(cpu_isa_pkg::op_ori, 5'd6, 5'd0, za));
		prog.push_back(imm_form(cpu_isa_pkg::op_xori, 5'd7, 5'd1, zb));
		for (int r = 1; r <= 7; r++) begin
			prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'(r), 5'd0, 15'(31 + r)));
		end
		prog.push_back(jump_word(24'd0));
		expect_store(32'h80, vm);
		expect_store(32'h84, vm >> s1);
		expect_store(32'h88, vm << s2);
		expect_store(32'h8c, rotate_right(vm, s3));
		expect_store(32'h90, vm + sign15(n15));
		expect_store(32'h94, {17'd0, za});
		expect_store(32'h98, vm ^ {17'd0, zb});
		start_program("shift_and_extend");
		run_program();
		compare_stores("shift_and_extend");
	endtask

	task automatic load_store_paths();
		logic [14:0] k;
		logic [19:0] idx;
		k = 15'($random(seed)) & 15'h7;
		idx = 20'($random(seed)) & 20'h3;
		clear_program();
		prog.push_back(movi_word(5'd1, 20'h00080));
		prog.push_back(imm_form(cpu_isa_pkg::op_lwi, 5'd2, 5'd1, k));
		// negative word offset
		prog.push_back(imm_form(cpu_isa_pkg::op_lwi, 5'd3, 5'd1, 15'h7ffe));
		prog.push_back(movi_word(5'd4, idx));
		prog.push_back(reg_form(cpu_isa_pkg::op_ls, 5'd5, 5'd1, 5'd4, 2'd2, cpu_isa_pkg::sub_lw));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd2, 5'd1, 15'd20));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd3, 5'd1, 15'd21));
		prog.push_back(reg_form(cpu_isa_pkg::op_ls, 5'd5, 5'd1, 5'd4, 2'd3, cpu_isa_pkg::sub_sw));
		prog.push_back(jump_word(24'd0));
		expect_store(32'hd0, mem_fill(32'h80 + {15'd0, k, 2'b00}));
		expect_store(32'hd4, mem_fill(32'h78));
		expect_store(32'h80 + ({12'd0, idx} << 3), mem_fill(32'h80 + ({12'd0, idx} << 2)));
		start_program("load_store_paths");
		run_program();
		compare_stores("load_store_paths");
		// two lwi and one lw
		checks++;
		if (load_count != 3) begin
			errors++;
			$display("error load_store_paths: load count expected 3 actual %0d", load_count);
		end
	endtask

	task automatic branch_decisions();
		logic [19:0] v20;
		logic [19:0] w20;
		v20 = 20'($random(seed));
		w20 = v20 ^ 20'h00001;
		clear_program();
		prog.push_back(movi_word(5'd1, v20));
		prog.push_back(movi_word(5'd2, v20));
		prog.push_back(movi_word(5'd3, w20));
		prog.push_back(branch_word(cpu_isa_pkg::sub_beq, 5'd1, 5'd2, 14'd4));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd1, 5'd0, 15'd64));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd1, 5'd0, 15'd65));
		prog.push_back(branch_word(cpu_isa_pkg::sub_beq, 5'd1, 5'd3, 14'd4));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd2, 5'd0, 15'd66));
		prog.push_back(branch_word(cpu_isa_pkg::sub_bne, 5'd1, 5'd3, 14'd4));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd3, 5'd0, 15'd67));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd3, 5'd0, 15'd68));
		prog.push_back(branch_word(cpu_isa_pkg::sub_bne, 5'd1, 5'd2, 14'd4));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd2, 5'd0, 15'd69));
		prog.push_back(jump_word(24'd0));
		expect_store(32'h104, sign20(v20));
		expect_store(32'h108, sign20(v20));
		expect_store(32'h110, sign20(w20));
		expect_store(32'h114, sign20(v20));
		start_program("branch_decisions");
		run_program();
		compare_stores("branch_decisions");
		check_skipped("branch_decisions", 32'h100);
		check_skipped("branch_decisions", 32'h10c);
	endtask

	task automatic jump_and_reset();
		logic [19:0] v20;
		v20 = 20'($random(seed));
		clear_program();
		prog.push_back(movi_word(5'd1, v20));
		prog.push_back(jump_word(24'd4));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd1, 5'd0, 15'd72));
		prog.push_back(imm_form(cpu_isa_pkg::op_swi, 5'd1, 5'd0, 15'd73));
		prog.push_back(jump_word(24'd0));
		expect_store(32'h124, sign20(v20));
		start_program("jump_and_reset");
		run_program();
		compare_stores("jump_and_reset");
		check_skipped("jump_and_reset", 32'h120);
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		seed = 51780;
		errors = 0;
		checks = 0;
		load_count = 0;
		reset = 1'b1;
		clear_program();
		load_memories();
		alu_register_ops();
		shift_and_extend();
		load_store_paths();
		branch_decisions();
		jump_and_reset();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top #(
	parameter logic [31:0] reset_pc = 32'h0
) (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	input  logic [31:0] dmem_rdata,
	output logic        dmem_read,
	output logic        dmem_write
);

	cpu_isa_pkg::isa_instr_u  instr;
	cpu_ctrl_pkg::alu_op_e    alu_op;
	cpu_ctrl_pkg::src2_sel_e  src2_sel;
	cpu_ctrl_pkg::ext_sel_e   ext_sel;
	cpu_ctrl_pkg::wb_sel_e    wb_sel;
	cpu_ctrl_pkg::pc_sel_e    pc_sel;

	logic        ir_load;
	logic        reg_write;
	logic        pc_load;
	logic        alu_zero;
	logic [4:0]  rf_addr_a;
	logic [4:0]  rf_addr_b;
	logic [4:0]  rf_addr_w;
	logic [31:0] rf_rdata_a;
	logic [31:0] rf_rdata_b;
	logic [31:0] rf_wdata;
	logic [31:0] alu_src1;
	logic [31:0] alu_src2;
	logic [31:0] alu_result;

	controller u_controller (
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.alu_zero   (alu_zero),
		.ir_load    (ir_load),
		.alu_op     (alu_op),
		.src2_sel   (src2_sel),
		.ext_sel    (ext_sel),
		.wb_sel     (wb_sel),
		.reg_write  (reg_write),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write),
		.pc_load    (pc_load),
		.pc_sel     (pc_sel)
	);

	datapath u_datapath (
		.clock      (clock),
		.reset      (reset),
		.imem_data  (imem_data),
		.ir_load    (ir_load),
		.src2_sel   (src2_sel),
		.ext_sel    (ext_sel),
		.wb_sel     (wb_sel),
		.rf_rdata_a (rf_rdata_a),
		.rf_rdata_b (rf_rdata_b),
		.alu_result (alu_result),
		.dmem_rdata (dmem_rdata),
		.instr      (instr),
		.rf_addr_a  (rf_addr_a),
		.rf_addr_b  (rf_addr_b),
		.rf_addr_w  (rf_addr_w),
		.alu_src1   (alu_src1),
		.alu_src2   (alu_src2),
		.rf_wdata   (rf_wdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata)
	);

	register_file u_register_file (
		.clock   (clock),
		.reset   (reset),
		.addr_a  (rf_addr_a),
		.addr_b  (rf_addr_b),
		.addr_w  (rf_addr_w),
		.wdata   (rf_wdata),
		.write   (reg_write),
		.rdata_a (rf_rdata_a),
		.rdata_b (rf_rdata_b)
	);

	alu u_alu (
		.op     (alu_op),
		.src1   (alu_src1),
		.src2   (alu_src2),
		.result (alu_result),
		.zero   (alu_zero)
	);

	program_counter #(
		.reset_pc (reset_pc)
	) u_program_counter (
		.clock        (clock),
		.reset        (reset),
		.load         (pc_load),
		.sel          (pc_sel),
		.instr_offset (instr[23:0]),
		.pc           (imem_addr)
	);

endmodule

// ==== hw/controller.sv ====
module controller (
	input  logic                     clock,
	input  logic                     reset,
	input  cpu_isa_pkg::isa_instr_u  instr,
	input  logic                     alu_zero,
	output logic                     ir_load,
	output cpu_ctrl_pkg::alu_op_e    alu_op,
	output cpu_ctrl_pkg::src2_sel_e  src2_sel,
	output cpu_ctrl_pkg::ext_sel_e   ext_sel,
	output cpu_ctrl_pkg::wb_sel_e    wb_sel,
	output logic                     reg_write,
	output logic                     dmem_read,
	output logic                     dmem_write,
	output logic                     pc_load,
	output cpu_ctrl_pkg::pc_sel_e    pc_sel
);

	cpu_ctrl_pkg::ctrl_state_e state;
	cpu_ctrl_pkg::ctrl_state_e next_state;

	logic dec_reg_write;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_branch;
	logic dec_jump;
	logic branch_taken;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= cpu_ctrl_pkg::st_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			cpu_ctrl_pkg::st_fetch:     next_state = cpu_ctrl_pkg::st_decode;
			cpu_ctrl_pkg::st_decode:    next_state = cpu_ctrl_pkg::st_execute;
			cpu_ctrl_pkg::st_execute:   next_state = cpu_ctrl_pkg::st_memaccess;
			cpu_ctrl_pkg::st_memaccess: next_state = cpu_ctrl_pkg::st_writeback;
			cpu_ctrl_pkg::st_writeback: next_state = cpu_ctrl_pkg::st_pcupdate;
			default:                    next_state = cpu_ctrl_pkg::st_fetch;
		endcase
	end

	// decode from the latched instruction, valid from execute on
	always_comb begin
		alu_op = cpu_ctrl_pkg::alu_add;
		src2_sel = cpu_ctrl_pkg::src2_reg;
		ext_sel = cpu_ctrl_pkg::ext_zero5;
		wb_sel = cpu_ctrl_pkg::wb_alu;
		dec_reg_write = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_branch = 1'b0;
		dec_jump = 1'b0;
		case (instr.r.opcode)
			cpu_isa_pkg::op_base: begin
				dec_reg_write = 1'b1;
				case (instr.r.sub[4:0])
					cpu_isa_pkg::sub_add: alu_op = cpu_ctrl_pkg::alu_add;
					cpu_isa_pkg::sub_sub: alu_op = cpu_ctrl_pkg::alu_sub;
					cpu_isa_pkg::sub_and: alu_op = cpu_ctrl_pkg::alu_and;
					cpu_isa_pkg::sub_or:  alu_op = cpu_ctrl_pkg::alu_or;
					cpu_isa_pkg::sub_xor: alu_op = cpu_ctrl_pkg::alu_xor;
					cpu_isa_pkg::sub_srli: begin
						alu_op = cpu_ctrl_pkg::alu_srl;
						src2_sel = cpu_ctrl_pkg::src2_imm;
					end
					cpu_isa_pkg::sub_slli: begin
						alu_op = cpu_ctrl_pkg::alu_sll;
						src2_sel = cpu_ctrl_pkg::src2_imm;
					end
					cpu_isa_pkg::sub_rotri: begin
						alu_op = cpu_ctrl_pkg::alu_ror;
						src2_sel = cpu_ctrl_pkg::src2_imm;
					end
					default: dec_reg_write = 1'b0;
				endcase
			end
			cpu_isa_pkg::op_addi: begin
				src2_sel = cpu_ctrl_pkg::src2_imm;
				ext_sel = cpu_ctrl_pkg::ext_sign15;
				dec_reg_write = 1'b1;
			end
			cpu_isa_pkg::op_ori: begin
				alu_op = cpu_ctrl_pkg::alu_or;
				src2_sel = cpu_ctrl_pkg::src2_imm;
				ext_sel = cpu_ctrl_pkg::ext_zero15;
				dec_reg_write = 1'b1;
			end
			cpu_isa_pkg::op_xori: begin
				alu_op = cpu_ctrl_pkg::alu_xor;
				src2_sel = cpu_ctrl_pkg::src2_imm;
				ext_sel = cpu_ctrl_pkg::ext_zero15;
				dec_reg_write = 1'b1;
			end
			cpu_isa_pkg::op_movi: begin
				ext_sel = cpu_ctrl_pkg::ext_sign20;
				wb_sel = cpu_ctrl_pkg::wb_imm;
				dec_reg_write = 1'b1;
			end
			cpu_isa_pkg::op_lwi: begin
				src2_sel = cpu_ctrl_pkg::src2_imm15;
				wb_sel = cpu_ctrl_pkg::wb_mem;
				dec_mem_read = 1'b1;
				dec_reg_write = 1'b1;
			end
			cpu_isa_pkg::op_swi: begin
				src2_sel = cpu_ctrl_pkg::src2_imm15;
				dec_mem_write = 1'b1;
			end
			cpu_isa_pkg::op_ls: begin
				src2_sel = cpu_ctrl_pkg::src2_reg_scaled;
				wb_sel = cpu_ctrl_pkg::wb_mem;
				if (instr.r.sub == cpu_isa_pkg::sub_lw) begin
					dec_mem_read = 1'b1;
					dec_reg_write = 1'b1;
				end else if (instr.r.sub == cpu_isa_pkg::sub_sw) begin
					dec_mem_write = 1'b1;
				end
			end
			cpu_isa_pkg::op_branch: begin
				alu_op = cpu_ctrl_pkg::alu_sub;
				dec_branch = 1'b1;
			end
			cpu_isa_pkg::op_jump: dec_jump = 1'b1;
			default: ;
		endcase
	end

	// beq/bne selected by bit 14
	assign branch_taken = dec_branch && ((instr.i.imm[14] == cpu_isa_pkg::sub_beq) ?
		alu_zero : !alu_zero);

	always_comb begin
		if (dec_jump) begin
			pc_sel = cpu_ctrl_pkg::pc_jump;
		end else if (branch_taken) begin
			pc_sel = cpu_ctrl_pkg::pc_branch;
		end else begin
			pc_sel = cpu_ctrl_pkg::pc_seq;
		end
	end

	assign ir_load = (state == cpu_ctrl_pkg::st_decode);
	assign dmem_read = dec_mem_read && (state == cpu_ctrl_pkg::st_memaccess);
	assign dmem_write = dec_mem_write && (state == cpu_ctrl_pkg::st_memaccess);
	assign reg_write = dec_reg_write && (state == cpu_ctrl_pkg::st_writeback);
	assign pc_load = (state == cpu_ctrl_pkg::st_pcupdate);

	assert property (@(posedge clock) disable iff (reset)
		!(dmem_read && dmem_write));

	assert property (@(posedge clock) disable iff (reset)
		reg_write |-> ((state == cpu_ctrl_pkg::st_writeback) ##1 pc_load));

endmodule

// ==== hw/datapath.sv ====
module datapath (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [31:0]              imem_data,
	input  logic                     ir_load,
	input  cpu_ctrl_pkg::src2_sel_e  src2_sel,
	input  cpu_ctrl_pkg::ext_sel_e   ext_sel,
	input  cpu_ctrl_pkg::wb_sel_e    wb_sel,
	input  logic [31:0]              rf_rdata_a,
	input  logic [31:0]              rf_rdata_b,
	input  logic [31:0]              alu_result,
	input  logic [31:0]              dmem_rdata,
	output cpu_isa_pkg::isa_instr_u  instr,
	output logic [4:0]               rf_addr_a,
	output logic [4:0]               rf_addr_b,
	output logic [4:0]               rf_addr_w,
	output logic [31:0]              alu_src1,
	output logic [31:0]              alu_src2,
	output logic [31:0]              rf_wdata,
	output logic [31:0]              dmem_addr,
	output logic [31:0]              dmem_wdata
);

	logic        exec_q;
	logic        mem_q;
	logic        late_q;
	logic [31:0] alu_out;
	logic [31:0] load_data;
	logic [31:0] ext_imm;
	logic [31:0] imm15_scaled;

	// phase tracking follows ir_load, which marks decode
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr <= '0;
			exec_q <= 1'b0;
			mem_q <= 1'b0;
			late_q <= 1'b0;
		end else begin
			if (ir_load) begin
				instr <= imem_data;
			end
			exec_q <= ir_load;
			mem_q <= exec_q;
			if (exec_q) begin
				late_q <= 1'b1;
			end else if (ir_load) begin
				late_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (exec_q) begin
			alu_out <= alu_result;
		end
		if (mem_q) begin
			load_data <= dmem_rdata;
		end
	end

	// port b reads rt after execute, for store data and branch compare
	assign rf_addr_a = instr.r.ra;
	assign rf_addr_b = late_q ? instr.r.rt : instr.r.rb;
	assign rf_addr_w = instr.r.rt;

	// shift amount sits in the rb field
	always_comb begin
		case (ext_sel)
			cpu_ctrl_pkg::ext_zero5:  ext_imm = {27'd0, instr.r.rb};
			cpu_ctrl_pkg::ext_sign15: ext_imm = {{17{instr.i.imm[14]}}, instr.i.imm[14:0]};
			cpu_ctrl_pkg::ext_zero15: ext_imm = {17'd0, instr.i.imm[14:0]};
			default:                  ext_imm = {{12{instr.i.imm[19]}}, instr.i.imm};
		endcase
	end

	assign imm15_scaled = {{15{instr.i.imm[14]}}, instr.i.imm[14:0], 2'b00};

	always_comb begin
		case (src2_sel)
			cpu_ctrl_pkg::src2_imm:   alu_src2 = ext_imm;
			cpu_ctrl_pkg::src2_imm15: alu_src2 = imm15_scaled;
			cpu_ctrl_pkg::src2_reg_scaled: alu_src2 = rf_rdata_b << instr.r.sv;
			default:                  alu_src2 = rf_rdata_b;
		endcase
	end

	always_comb begin
		case (wb_sel)
			cpu_ctrl_pkg::wb_imm: rf_wdata = ext_imm;
			cpu_ctrl_pkg::wb_mem: rf_wdata = load_data;
			default:              rf_wdata = alu_out;
		endcase
	end

	assign alu_src1 = rf_rdata_a;
	assign dmem_addr = alu_out;
	assign dmem_wdata = rf_rdata_b;

endmodule

// ==== hw/program_counter.sv ====
module program_counter #(
	parameter logic [31:0] reset_pc = 32'h0
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load,
	input  cpu_ctrl_pkg::pc_sel_e sel,
	input  logic [23:0]           instr_offset,
	output logic [31:0]           pc
);

	logic [31:0] branch_target;
	logic [31:0] jump_target;

	// halfword-scaled offsets
	assign branch_target = pc + {{17{instr_offset[13]}}, instr_offset[13:0], 1'b0};
	assign jump_target = pc + {{7{instr_offset[23]}}, instr_offset, 1'b0};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (load) begin
			case (sel)
				cpu_ctrl_pkg::pc_branch: pc <= branch_target;
				cpu_ctrl_pkg::pc_jump:   pc <= jump_target;
				default:                 pc <= pc + 32'd4;
			endcase
		end
	end

endmodule

// ==== hw/register_file.sv ====
module register_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  addr_a,
	input  logic [4:0]  addr_b,
	input  logic [4:0]  addr_w,
	input  logic [31:0] wdata,
	input  logic        write,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	logic [31:0] regs [32];

	// r0 never takes a write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write && (addr_w != 5'd0)) begin
			regs[addr_w] <= wdata;
		end
	end

	assign rdata_a = (addr_a == 5'd0) ? 32'd0 : regs[addr_a];
	assign rdata_b = (addr_b == 5'd0) ? 32'd0 : regs[addr_b];

endmodule

// ==== hw/alu.sv ====
module alu (
	input  cpu_ctrl_pkg::alu_op_e op,
	input  logic [31:0]           src1,
	input  logic [31:0]           src2,
	output logic [31:0]           result,
	output logic                  zero
);

	logic [4:0]  shamt;
	logic [63:0] rot;

	assign shamt = src2[4:0];

	// rotate by shifting the doubled word
	assign rot = {src1, src1} >> shamt;

	always_comb begin
		case (op)
			cpu_ctrl_pkg::alu_add: result = src1 + src2;
			cpu_ctrl_pkg::alu_sub: result = src1 - src2;
			cpu_ctrl_pkg::alu_and: result = src1 & src2;
			cpu_ctrl_pkg::alu_or:  result = src1 | src2;
			cpu_ctrl_pkg::alu_xor: result = src1 ^ src2;
			cpu_ctrl_pkg::alu_srl: result = src1 >> shamt;
			cpu_ctrl_pkg::alu_sll: result = src1 << shamt;
			default:               result = rot[31:0];
		endcase
	end

	// branch compare uses sub
	assign zero = (result == 32'd0);

	// decode always settles to a known op
	always_comb begin
		assert #0 (!$isunknown(op));
	end

endmodule

// ==== hw/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		st_fetch     = 3'd0,
		st_decode    = 3'd1,
		st_execute   = 3'd2,
		st_memaccess = 3'd3,
		st_writeback = 3'd4,
		st_pcupdate  = 3'd5
	} ctrl_state_e;

	typedef enum logic [1:0] {
		pc_seq    = 2'd0,
		pc_branch = 2'd1,
		pc_jump   = 2'd2
	} pc_sel_e;

	typedef enum logic [1:0] {
		src2_reg        = 2'd0,
		src2_imm        = 2'd1,
		src2_imm15      = 2'd2,
		src2_reg_scaled = 2'd3
	} src2_sel_e;

	typedef enum logic [1:0] {
		ext_zero5  = 2'd0,
		ext_sign15 = 2'd1,
		ext_zero15 = 2'd2,
		ext_sign20 = 2'd3
	} ext_sel_e;

	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_imm = 2'd1,
		wb_mem = 2'd2
	} wb_sel_e;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_srl = 3'd5,
		alu_sll = 3'd6,
		alu_ror = 3'd7
	} alu_op_e;

endpackage

// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// major opcodes, instruction bits 30:25
	localparam logic [5:0] op_base   = 6'b100000;
	localparam logic [5:0] op_addi   = 6'b101000;
	localparam logic [5:0] op_ori    = 6'b101100;
	localparam logic [5:0] op_xori   = 6'b101011;
	localparam logic [5:0] op_movi   = 6'b100010;
	localparam logic [5:0] op_lwi    = 6'b000010;
	localparam logic [5:0] op_swi    = 6'b001010;
	localparam logic [5:0] op_ls     = 6'b011100;
	localparam logic [5:0] op_branch = 6'b100110;
	localparam logic [5:0] op_jump   = 6'b100100;

	// base group, bits 4:0
	localparam logic [4:0] sub_add   = 5'b00000;
	localparam logic [4:0] sub_sub   = 5'b00001;
	localparam logic [4:0] sub_and   = 5'b00010;
	localparam logic [4:0] sub_xor   = 5'b00011;
	localparam logic [4:0] sub_or    = 5'b00100;
	localparam logic [4:0] sub_slli  = 5'b01000;
	localparam logic [4:0] sub_srli  = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	// load/store group, bits 7:0
	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

	// branch group, bit 14
	localparam logic sub_beq = 1'b0;
	localparam logic sub_bne = 1'b1;

	typedef struct packed {
		logic       spare;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub;
	} isa_reg_t;

	// imm5, imm14, imm15 are the low bits of imm
	typedef struct packed {
		logic        spare;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [19:0] imm;
	} isa_imm_t;

	typedef union packed {
		isa_reg_t r;
		isa_imm_t i;
	} isa_instr_u;

endpackage
